// File: design/mcu_pwr_pkg.sv
/*
  power and interrupt control package
  widths, core interrupt vector positions and the power sequencer states
*/
package mcu_pwr_pkg;

  // fast source order is timer 1..3, dma done, spi, spi flash, ao gpio 0..7, dma window, ext
  localparam int unsigned FAST_IRQ_NUM = 16;
  localparam int unsigned IRQ_NUM = 32;
  localparam int unsigned STD_IRQ_NUM = 3;

  // positions in the core interrupt vector
  localparam int unsigned IRQ_SOFTWARE_BIT = 3;
  localparam int unsigned IRQ_TIMER_BIT = 7;
  localparam int unsigned IRQ_EXTERNAL_BIT = 11;
  localparam int unsigned IRQ_FAST_LSB = 16;

  typedef logic [FAST_IRQ_NUM-1:0] fast_irq_t;
  typedef logic [IRQ_NUM-1:0] irq_vec_t;

  // bit 0 software, bit 1 timer 0, bit 2 external
  typedef logic [STD_IRQ_NUM-1:0] std_irq_t;

  // power-down walks top to bottom, power-up continues from OFF
  typedef enum logic [3:0] {
    ACTIVE,
    CLK_OFF,
    ISOLATE,
    RESET,
    SWITCH_OFF,
    OFF,
    SWITCH_ON,
    RELEASE_RST,
    RELEASE_ISO
  } pwr_state_e;

endpackage

// File: design/pwr_ctrl_if.sv
/*
  domain power control bundle
  switch, isolation, reset and clock gate enables with the switch acknowledge
*/
`timescale 1ns/1ps

interface pwr_ctrl_if;

  // all active low
  logic pwrgate_en_n;
  logic isogate_en_n;
  logic rst_n;
  logic clkgate_en_n;

  // low once the switch reports the domain powered
  logic pwrgate_ack_n;

  modport seq (
    output pwrgate_en_n,
    output isogate_en_n,
    output rst_n,
    output clkgate_en_n,
    input  pwrgate_ack_n
  );

  modport pad (
    input  pwrgate_en_n,
    input  isogate_en_n,
    input  rst_n,
    input  clkgate_en_n,
    output pwrgate_ack_n
  );

endinterface

// File: design/fast_irq_capture.sv
/*
  fast interrupt capture
  rising edge detect into pending bits, standard line sampling, wake request
*/
`timescale 1ns/1ps

module fast_irq_capture
  import mcu_pwr_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  fast_irq_t fast_irq_i,
  input  fast_irq_t fast_irq_clear_i,
  input  std_irq_t  std_irq_i,
  output fast_irq_t pending_o,
  output std_irq_t  std_irq_o,
  output logic      wake_req_o
);

  fast_irq_t src_q;
  fast_irq_t pending_q;
  fast_irq_t pending_d;
  fast_irq_t rise;
  std_irq_t  std_q;

  // low at the previous edge, high now
  assign rise = fast_irq_i & ~src_q;

  // a new edge beats a clear in the same cycle
  assign pending_d = (pending_q & ~fast_irq_clear_i) | rise;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q     <= '0;
      pending_q <= '0;
      std_q     <= '0;
    end else begin
      src_q     <= fast_irq_i;
      pending_q <= pending_d;
      std_q     <= std_irq_i;
    end
  end

  assign pending_o = pending_q;
  assign std_irq_o = std_q;

  // from registers only, so the sequencer sees a clean level
  assign wake_req_o = (|pending_q) | (|std_q);

endmodule

// File: design/domain_power_seq.sv
/*
  cpu domain power sequencer
  ordered power-down on core sleep and power-up on wake, paced by the switch ack
*/
`timescale 1ns/1ps

module domain_power_seq
  import mcu_pwr_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           core_sleep_i,
  input  logic           wake_req_i,
  pwr_ctrl_if.seq        pwr
);

  pwr_state_e state_q;
  pwr_state_e state_d;

  logic switch_n;
  logic iso_n;
  logic rst_n;
  logic clkgate_n;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ACTIVE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ACTIVE: begin
        if (core_sleep_i && !wake_req_i) begin
          state_d = CLK_OFF;
        end
      end
      CLK_OFF: state_d = ISOLATE;
      ISOLATE: state_d = RESET;
      RESET: state_d = SWITCH_OFF;
      // hold until the switch reports the domain unpowered
      SWITCH_OFF: begin
        if (pwr.pwrgate_ack_n) begin
          state_d = OFF;
        end
      end
      OFF: begin
        if (wake_req_i) begin
          state_d = SWITCH_ON;
        end
      end
      SWITCH_ON: begin
        if (!pwr.pwrgate_ack_n) begin
          state_d = RELEASE_RST;
        end
      end
      RELEASE_RST: state_d = RELEASE_ISO;
      RELEASE_ISO: state_d = ACTIVE;
      default: state_d = ACTIVE;
    endcase
  end

  // one control moves per step
  always_comb begin
    switch_n  = 1'b0;
    iso_n     = 1'b1;
    rst_n     = 1'b1;
    clkgate_n = 1'b1;
    unique case (state_q)
      ACTIVE: begin
        clkgate_n = 1'b1;
      end
      CLK_OFF: begin
        clkgate_n = 1'b0;
      end
      ISOLATE: begin
        clkgate_n = 1'b0;
        iso_n     = 1'b0;
      end
      RESET, SWITCH_ON: begin
        clkgate_n = 1'b0;
        iso_n     = 1'b0;
        rst_n     = 1'b0;
      end
      SWITCH_OFF, OFF: begin
        clkgate_n = 1'b0;
        iso_n     = 1'b0;
        rst_n     = 1'b0;
        switch_n  = 1'b1;
      end
      RELEASE_RST: begin
        clkgate_n = 1'b0;
        iso_n     = 1'b0;
      end
      RELEASE_ISO: begin
        clkgate_n = 1'b0;
      end
      default: begin
        switch_n = 1'b0;
      end
    endcase
  end

  assign pwr.pwrgate_en_n = switch_n;
  assign pwr.isogate_en_n = iso_n;
  assign pwr.rst_n        = rst_n;
  assign pwr.clkgate_en_n = clkgate_n;

endmodule

// File: design/domain_ctrl_out.sv
/*
  domain pin and interrupt vector output stage
  registers the power pins, merges debug reset and packs the core irq vector
*/
`timescale 1ns/1ps

module domain_ctrl_out
  import mcu_pwr_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  fast_irq_t pending_i,
  input  std_irq_t  std_irq_i,
  input  logic      debug_reset_n_i,
  input  logic      switch_ack_n_i,
  pwr_ctrl_if.pad   pwr,
  output irq_vec_t  irq_o,
  output fast_irq_t irq_fast_o,
  output logic      switch_n_o,
  output logic      iso_n_o,
  output logic      domain_rst_n_o,
  output logic      clkgate_en_n_o
);

  irq_vec_t irq_d;
  irq_vec_t irq_q;
  fast_irq_t fast_q;

  // unused positions stay zero
  always_comb begin
    irq_d = '0;
    irq_d[IRQ_FAST_LSB +: FAST_IRQ_NUM] = pending_i;
    irq_d[IRQ_SOFTWARE_BIT] = std_irq_i[0];
    irq_d[IRQ_TIMER_BIT] = std_irq_i[1];
    irq_d[IRQ_EXTERNAL_BIT] = std_irq_i[2];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_q          <= '0;
      fast_q         <= '0;
      switch_n_o     <= 1'b0;
      iso_n_o        <= 1'b1;
      domain_rst_n_o <= 1'b0;
      clkgate_en_n_o <= 1'b1;
    end else begin
      irq_q          <= irq_d;
      fast_q         <= pending_i;
      switch_n_o     <= pwr.pwrgate_en_n;
      iso_n_o        <= pwr.isogate_en_n;
      // debug module reset holds the domain in reset too
      domain_rst_n_o <= pwr.rst_n & debug_reset_n_i;
      clkgate_en_n_o <= pwr.clkgate_en_n;
    end
  end

  assign irq_o      = irq_q;
  assign irq_fast_o = fast_q;

  // switch ack goes straight back to the sequencer
  assign pwr.pwrgate_ack_n = switch_ack_n_i;

endmodule

// File: design/mcu_pwr_ctrl.sv
/*
  always-on power and interrupt control for one switchable cpu domain
  ties interrupt capture, power sequencer and output stage together
*/
`timescale 1ns/1ps

module mcu_pwr_ctrl
  import mcu_pwr_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  fast_irq_t fast_irq_i,
  input  fast_irq_t fast_irq_clear_i,
  input  std_irq_t  std_irq_i,
  input  logic      core_sleep_i,
  input  logic      switch_ack_n_i,
  input  logic      debug_reset_n_i,
  output irq_vec_t  irq_o,
  output fast_irq_t irq_fast_o,
  output logic      switch_n_o,
  output logic      iso_n_o,
  output logic      domain_rst_n_o,
  output logic      clkgate_en_n_o
);

  fast_irq_t pending;
  std_irq_t  std_irq;
  logic      wake_req;

  pwr_ctrl_if pwr_if ();

  fast_irq_capture u_capture (
    .clk_i,
    .arst_n_i,
    .fast_irq_i,
    .fast_irq_clear_i,
    .std_irq_i,
    .pending_o  (pending),
    .std_irq_o  (std_irq),
    .wake_req_o (wake_req)
  );

  domain_power_seq u_seq (
    .clk_i,
    .arst_n_i,
    .core_sleep_i,
    .wake_req_i (wake_req),
    .pwr        (pwr_if.seq)
  );

  domain_ctrl_out u_out (
    .clk_i,
    .arst_n_i,
    .pending_i       (pending),
    .std_irq_i       (std_irq),
    .debug_reset_n_i,
    .switch_ack_n_i,
    .pwr             (pwr_if.pad),
    .irq_o,
    .irq_fast_o,
    .switch_n_o,
    .iso_n_o,
    .domain_rst_n_o,
    .clkgate_en_n_o
  );

endmodule

// File: testbench/mcu_pwr_ctrl_assert.sv
/*
  power sequencer checks
  single step control changes, safe switch off and release after power returns
*/
`timescale 1ns/1ps

module mcu_pwr_ctrl_assert (
  input logic clk_i,
  input logic arst_n_i,
  input logic switch_n_i,
  input logic iso_n_i,
  input logic rst_n_i,
  input logic clkgate_n_i,
  input logic ack_n_i
);

  logic [3:0] ctrl;

  assign ctrl = {switch_n_i, iso_n_i, rst_n_i, clkgate_n_i};

  // powered and released while in reset
  reset_levels: assert property (@(posedge clk_i) !arst_n_i |-> ctrl == 4'b0111)
    else $error("domain controls not at their reset levels");

  one_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(ctrl ^ $past(ctrl)))
    else $error("more than one domain control changed in one cycle");

  switch_off_safe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(switch_n_i) |-> !iso_n_i && !rst_n_i)
    else $error("switch turned off with isolation or reset released");

  iso_after_power: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(iso_n_i) |-> !ack_n_i)
    else $error("isolation released before the switch reported power");

  clk_after_power: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(clkgate_n_i) |-> !ack_n_i)
    else $error("clock gate released before the switch reported power");

endmodule

bind domain_power_seq mcu_pwr_ctrl_assert u_seq_assert (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .switch_n_i  (switch_n),
  .iso_n_i     (iso_n),
  .rst_n_i     (rst_n),
  .clkgate_n_i (clkgate_n),
  .ack_n_i     (pwr.pwrgate_ack_n)
);

// File: testbench/tb_mcu_pwr_ctrl.sv
/*
  testbench for the always-on power and interrupt controller
  table driven interrupt capture and domain power sequencing checks
*/
`timescale 1ns/1ps

module tb_mcu_pwr_ctrl;

  localparam int MAX_STEPS = 32;
  localparam int SETTLE_CYCLES = 6;

  // fast sources used by the table
  localparam logic [15:0] F_TIMER1 = 16'h0001;
  localparam logic [15:0] F_SPI = 16'h0010;
  localparam logic [15:0] F_GPIO3 = 16'h0200;
  localparam logic [15:0] F_ALL = 16'hffff;

  // pins as {switch_n, iso_n, rst_n, clkgate_n}
  localparam logic [3:0] PINS_ON = 4'b0111;
  localparam logic [3:0] PINS_OFF = 4'b1000;
  localparam logic [3:0] PINS_RST = 4'b0101;

  localparam logic [1:0] ORD_NONE = 2'd0;
  localparam logic [1:0] ORD_DOWN = 2'd1;
  localparam logic [1:0] ORD_UP = 2'd2;

  // pin change events
  localparam logic [3:0] EV_GATE_CLK = 4'd0;
  localparam logic [3:0] EV_ISOLATE = 4'd1;
  localparam logic [3:0] EV_HOLD_RST = 4'd2;
  localparam logic [3:0] EV_SWITCH_OFF = 4'd3;
  localparam logic [3:0] EV_SWITCH_ON = 4'd4;
  localparam logic [3:0] EV_FREE_RST = 4'd5;
  localparam logic [3:0] EV_FREE_ISO = 4'd6;
  localparam logic [3:0] EV_FREE_CLK = 4'd7;

  // expected order with the first event in the low nibble
  localparam logic [15:0] DOWN_SEQ = {EV_SWITCH_OFF, EV_HOLD_RST, EV_ISOLATE, EV_GATE_CLK};
  localparam logic [15:0] UP_SEQ = {EV_FREE_CLK, EV_FREE_ISO, EV_FREE_RST, EV_SWITCH_ON};

  typedef struct packed {
    logic [15:0] fast;
    logic [15:0] clear;
    logic [2:0]  std_irq;
    logic        sleep;
    logic        dbg_n;
    logic        wait_pins;
    logic [1:0]  order;
    logic [15:0] exp_fast;
    logic [31:0] exp_irq;
    logic [3:0]  exp_pins;
  } step_t;

  logic        clk_i;
  logic        arst_n_i;
  logic [15:0] fast_irq_i;
  logic [15:0] fast_irq_clear_i;
  logic [2:0]  std_irq_i;
  logic        core_sleep_i;
  logic        switch_ack_n_i;
  logic        debug_reset_n_i;
  logic [31:0] irq_o;
  logic [15:0] irq_fast_o;
  logic        switch_n_o;
  logic        iso_n_o;
  logic        domain_rst_n_o;
  logic        clkgate_en_n_o;
  logic [3:0]  pins;

  step_t       steps[MAX_STEPS];
  int          n_steps;
  int          cycle_limit;
  logic [3:0]  pin_events[$];

  mcu_pwr_ctrl dut0 (
    .clk_i,
    .arst_n_i,
    .fast_irq_i,
    .fast_irq_clear_i,
    .std_irq_i,
    .core_sleep_i,
    .switch_ack_n_i,
    .debug_reset_n_i,
    .irq_o,
    .irq_fast_o,
    .switch_n_o,
    .iso_n_o,
    .domain_rst_n_o,
    .clkgate_en_n_o
  );

  assign pins = {switch_n_o, iso_n_o, domain_rst_n_o, clkgate_en_n_o};

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // switch model whose ack follows the enable after 1 to 6 cycles
  initial begin
    int ack_wait;
    void'($urandom(32'h4ca7_1bfc));
    ack_wait = 0;
    switch_ack_n_i <= 1'b0;
    forever begin
      @(posedge clk_i);
      if (switch_n_o == switch_ack_n_i) begin
        ack_wait = 0;
      end else if (ack_wait == 0) begin
        ack_wait = 1 + int'($urandom % 6);
      end else if (ack_wait == 1) begin
        switch_ack_n_i <= switch_n_o;
        ack_wait = 0;
      end else begin
        ack_wait = ack_wait - 1;
      end
    end
  end

  // records every pin edge in the order seen
  initial begin
    logic [3:0] prev;
    prev = PINS_ON;
    forever begin
      @(negedge clk_i);
      if (arst_n_i) begin
        if (prev[0] && !pins[0]) pin_events.push_back(EV_GATE_CLK);
        if (prev[2] && !pins[2]) pin_events.push_back(EV_ISOLATE);
        if (prev[1] && !pins[1]) pin_events.push_back(EV_HOLD_RST);
        if (!prev[3] && pins[3]) pin_events.push_back(EV_SWITCH_OFF);
        if (prev[3] && !pins[3]) pin_events.push_back(EV_SWITCH_ON);
        if (!prev[1] && pins[1]) pin_events.push_back(EV_FREE_RST);
        if (!prev[2] && pins[2]) pin_events.push_back(EV_FREE_ISO);
        if (!prev[0] && pins[0]) pin_events.push_back(EV_FREE_CLK);
      end
      prev = pins;
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    while (cycles < cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Test failed");
    $fatal(1, "timeout");
  end

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_order(input logic [1:0] order);
    logic [15:0] seq;
    seq = (order == ORD_DOWN) ? DOWN_SEQ : UP_SEQ;
    check_eq(32'(pin_events.size()), 32'd4, "number of power pin changes");
    for (int k = 0; k < 4; k++) begin
      check_eq(32'(pin_events[k]), 32'(seq[k*4 +: 4]), "power pin change order");
    end
  endtask

  task automatic add_step(input logic [15:0] fast, input logic [15:0] clear,
                          input logic [2:0] std_irq, input logic sleep, input logic dbg_n,
                          input logic wait_pins, input logic [1:0] order,
                          input logic [15:0] exp_fast, input logic [31:0] exp_irq,
                          input logic [3:0] exp_pins);
    steps[n_steps] = {fast, clear, std_irq, sleep, dbg_n, wait_pins, order,
                      exp_fast, exp_irq, exp_pins};
    n_steps++;
  endtask

  task automatic build_table();
    n_steps = 0;
    // capture, clear while held high, set beating clear
    add_step(F_TIMER1, 16'h0, 3'b000, 1'b0, 1'b1, 1'b0, ORD_NONE,
             F_TIMER1, 32'h0001_0000, PINS_ON);
    add_step(F_TIMER1, F_TIMER1, 3'b000, 1'b0, 1'b1, 1'b0, ORD_NONE,
             16'h0, 32'h0, PINS_ON);
    add_step(16'h0, 16'h0, 3'b000, 1'b0, 1'b1, 1'b0, ORD_NONE, 16'h0, 32'h0, PINS_ON);
    add_step(F_SPI | F_TIMER1, 16'h0, 3'b000, 1'b0, 1'b1, 1'b0, ORD_NONE,
             16'h0011, 32'h0011_0000, PINS_ON);
    add_step(F_SPI, 16'h0, 3'b000, 1'b0, 1'b1, 1'b0, ORD_NONE,
             16'h0011, 32'h0011_0000, PINS_ON);
    add_step(F_SPI | F_TIMER1, F_TIMER1, 3'b000, 1'b0, 1'b1, 1'b0, ORD_NONE,
             16'h0011, 32'h0011_0000, PINS_ON);
    // standard lines at 3, 7 and 11
    add_step(F_SPI | F_TIMER1, 16'h0, 3'b101, 1'b0, 1'b1, 1'b0, ORD_NONE,
             16'h0011, 32'h0011_0808, PINS_ON);
    add_step(F_SPI | F_TIMER1, 16'h0, 3'b010, 1'b0, 1'b1, 1'b0, ORD_NONE,
             16'h0011, 32'h0011_0080, PINS_ON);
    add_step(16'h0, F_ALL, 3'b000, 1'b0, 1'b1, 1'b0, ORD_NONE, 16'h0, 32'h0, PINS_ON);
    // sleep, then wake on a fast source
    add_step(16'h0, 16'h0, 3'b000, 1'b1, 1'b1, 1'b1, ORD_DOWN, 16'h0, 32'h0, PINS_OFF);
    add_step(F_GPIO3, 16'h0, 3'b000, 1'b1, 1'b1, 1'b1, ORD_UP,
             F_GPIO3, 32'h0200_0000, PINS_ON);
    add_step(F_GPIO3, F_GPIO3, 3'b000, 1'b0, 1'b1, 1'b0, ORD_NONE, 16'h0, 32'h0, PINS_ON);
    // debug module reset
    add_step(16'h0, 16'h0, 3'b000, 1'b0, 1'b0, 1'b0, ORD_NONE, 16'h0, 32'h0, PINS_RST);
    add_step(16'h0, 16'h0, 3'b000, 1'b0, 1'b1, 1'b0, ORD_NONE, 16'h0, 32'h0, PINS_ON);
    // sleep, then wake on the external line
    add_step(16'h0, 16'h0, 3'b000, 1'b1, 1'b1, 1'b1, ORD_DOWN, 16'h0, 32'h0, PINS_OFF);
    add_step(16'h0, 16'h0, 3'b100, 1'b1, 1'b1, 1'b1, ORD_UP, 16'h0, 32'h0000_0800, PINS_ON);
    add_step(16'h0, 16'h0, 3'b000, 1'b0, 1'b1, 1'b0, ORD_NONE, 16'h0, 32'h0, PINS_ON);
  endtask

  initial begin
    step_t s;
    build_table();
    cycle_limit = n_steps * 40 + 200;
    arst_n_i <= 1'b0;
    fast_irq_i <= '0;
    fast_irq_clear_i <= '0;
    std_irq_i <= '0;
    core_sleep_i <= 1'b0;
    debug_reset_n_i <= 1'b1;

    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    check_eq(32'(pins), 32'(PINS_RST), "power pins in reset");
    check_eq(irq_o, 32'h0, "irq_o in reset");
    @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_eq(32'(domain_rst_n_o), 32'h0, "domain_rst_n_o at reset release");
    @(negedge clk_i);
    check_eq(32'(pins), 32'(PINS_ON), "power pins after reset");
    check_eq(irq_o, 32'h0, "irq_o after reset");
    check_eq(32'(irq_fast_o), 32'h0, "irq_fast_o after reset");

    for (int i = 0; i < n_steps; i++) begin
      s = steps[i];
      @(posedge clk_i);
      pin_events.delete();
      fast_irq_i <= s.fast;
      fast_irq_clear_i <= s.clear;
      std_irq_i <= s.std_irq;
      core_sleep_i <= s.sleep;
      debug_reset_n_i <= s.dbg_n;
      // clear is a one cycle pulse
      @(posedge clk_i);
      fast_irq_clear_i <= '0;
      if (s.wait_pins) begin
        @(negedge clk_i);
        while (pins != s.exp_pins) @(negedge clk_i);
        @(negedge clk_i);
      end else begin
        // interrupt lines reach the outputs two edges after the input
        repeat (2) @(negedge clk_i);
        check_eq(32'(irq_fast_o), 32'(s.exp_fast), "irq_fast_o two edges after the input");
        check_eq(irq_o, s.exp_irq, "irq_o two edges after the input");
        repeat (SETTLE_CYCLES - 2) @(negedge clk_i);
      end
      check_eq(32'(irq_fast_o), 32'(s.exp_fast), "irq_fast_o");
      check_eq(irq_o, s.exp_irq, "irq_o");
      check_eq(32'(pins), 32'(s.exp_pins), "power pins");
      if (s.order != ORD_NONE) begin
        check_order(s.order);
      end
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: mcu_pwr_ctrl.f
design/mcu_pwr_pkg.sv
design/pwr_ctrl_if.sv
design/fast_irq_capture.sv
design/domain_power_seq.sv
design/domain_ctrl_out.sv
design/mcu_pwr_ctrl.sv
testbench/mcu_pwr_ctrl_assert.sv
testbench/tb_mcu_pwr_ctrl.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
  --top-module tb_mcu_pwr_ctrl \
  -f mcu_pwr_ctrl.f \
  -o sim_tb
./obj_dir/sim_tb
